//--- core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path and PC width
`define CORE_XLEN 32

// Register file address width, 32 general registers
`define CORE_REG_AW 5

// PC value after reset
`define CORE_RESET_PC 32'h8000_0000

// APB address width, byte offsets into the host register map
`define CORE_APB_AW 8

`endif

//--- rv_isa_pkg.sv
`include "core_params.svh"

package rv_isa_pkg;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 values used by the decoder
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_PRIV = 3'b000;

    // imm12 field that tells ebreak apart from ecall
    localparam logic [11:0] IMM_EBREAK = 12'h001;

    // Execute command
    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0,  // PC step only
        CMD_ADD  = 2'd1,  // rd = src1 + src2
        CMD_PASS = 2'd2,  // rd = src2
        CMD_HALT = 2'd3   // stop the core
    } cmd_e;

    typedef struct packed {
        logic [11:0]             imm12;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]             imm20;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } u_fmt_t;

    // Same 32-bit word seen as I-type or U-type
    typedef union packed {
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

endpackage

//--- core_apb_pkg.sv
`include "core_params.svh"

package core_apb_pkg;

    // Host register map, byte offsets
    localparam logic [`CORE_APB_AW-1:0] ADDR_INST     = 8'h00;  // instruction register, R/W
    localparam logic [`CORE_APB_AW-1:0] ADDR_PC       = 8'h04;  // program counter, RO
    localparam logic [`CORE_APB_AW-1:0] ADDR_STATUS   = 8'h08;  // status word, RO

    // General register n at ADDR_REG_BASE + 4*n, RO
    localparam logic [`CORE_APB_AW-1:0] ADDR_REG_BASE = 8'h80;

    // Status word bit layout
    localparam int unsigned STAT_HALTED  = 0;  // ebreak seen
    localparam int unsigned STAT_ILLEGAL = 1;  // sticky, unsupported word executed

endpackage

//--- core_idu.sv
`include "core_params.svh"

module core_idu import rv_isa_pkg::*; (
    input  inst_u                   inst,
    output logic [`CORE_REG_AW-1:0] rs1_addr,
    output logic [`CORE_REG_AW-1:0] rd,
    output logic [`CORE_XLEN-1:0]   imm,
    output logic                    use_pc,
    output cmd_e                    cmd
);

    localparam logic [1:0] IMM_N = 2'd0;
    localparam logic [1:0] IMM_I = 2'd1;
    localparam logic [1:0] IMM_U = 2'd2;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       reg1_ren;
    logic       wreg_ren;
    logic [1:0] imm_sel;

    // opcode and funct3 sit at the same place in both formats
    assign opcode = inst.i_fmt.opcode;
    assign funct3 = inst.i_fmt.funct3;

    // Unused fields read as x0
    assign rs1_addr = reg1_ren ? inst.i_fmt.rs1 : '0;
    assign rd       = wreg_ren ? inst.u_fmt.rd  : '0;

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = {{(`CORE_XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
            IMM_U:   imm = {inst.u_fmt.imm20, {(`CORE_XLEN-20){1'b0}}};
            default: imm = '0;
        endcase
    end

    always_comb begin
        imm_sel  = IMM_N;
        cmd      = CMD_NOP;
        use_pc   = 1'b0;
        reg1_ren = 1'b0;
        wreg_ren = 1'b0;

        casez ({funct3, opcode})
            {F3_ADDI, OPC_OPIMM}: begin
                imm_sel  = IMM_I;
                cmd      = CMD_ADD;
                reg1_ren = 1'b1;
                wreg_ren = 1'b1;
            end
            {3'b???, OPC_AUIPC}: begin
                imm_sel  = IMM_U;
                cmd      = CMD_ADD;
                use_pc   = 1'b1;  // pc + imm
                wreg_ren = 1'b1;
            end
            {3'b???, OPC_LUI}: begin
                imm_sel  = IMM_U;
                cmd      = CMD_PASS;
                wreg_ren = 1'b1;
            end
            {F3_PRIV, OPC_SYSTEM}: begin
                // ecall and friends fall through as illegal
                if (inst.i_fmt.imm12 == IMM_EBREAK) begin
                    cmd = CMD_HALT;
                end
            end
            default: begin
                cmd = CMD_NOP;  // unsupported word
            end
        endcase
    end

endmodule

//--- core_regfile.sv
`include "core_params.svh"

module core_regfile (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CORE_REG_AW-1:0] rs1_addr,
    input  logic [`CORE_REG_AW-1:0] host_raddr,
    input  logic                    wen,
    input  logic [`CORE_REG_AW-1:0] waddr,
    input  logic [`CORE_XLEN-1:0]   wdata,
    output logic [`CORE_XLEN-1:0]   rs1_data,
    output logic [`CORE_XLEN-1:0]   host_rdata
);

    localparam int unsigned NREGS = 1 << `CORE_REG_AW;

    // x0 has no storage
    logic [`CORE_XLEN-1:0] regs [1:NREGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Decoder read port
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    // Host read port
    always_comb begin
        if (host_raddr == '0) begin
            host_rdata = '0;
        end else begin
            host_rdata = regs[host_raddr];
        end
    end

endmodule

//--- core_exu.sv
`include "core_params.svh"

module core_exu import rv_isa_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    exec_valid,
    input  logic [`CORE_XLEN-1:0]   rs1_data,
    input  logic [`CORE_REG_AW-1:0] rd,
    input  logic [`CORE_XLEN-1:0]   imm,
    input  logic                    use_pc,
    input  cmd_e                    cmd,
    output logic                    wen,
    output logic [`CORE_REG_AW-1:0] waddr,
    output logic [`CORE_XLEN-1:0]   wdata,
    output logic [`CORE_XLEN-1:0]   pc,
    output logic                    halted,
    output logic                    illegal
);

    localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

    logic [`CORE_XLEN-1:0] src1;
    logic [`CORE_XLEN-1:0] result;

    assign src1 = use_pc ? pc : rs1_data;  // auipc takes the PC

    always_comb begin
        case (cmd)
            CMD_ADD:  result = src1 + imm;
            CMD_PASS: result = imm;
            default:  result = '0;
        endcase
    end

    // Write back lands at the end of the exec cycle
    assign wen   = exec_valid && ((cmd == CMD_ADD) || (cmd == CMD_PASS));
    assign waddr = rd;
    assign wdata = result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `CORE_RESET_PC;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (exec_valid && !halted) begin
            // ebreak keeps the PC on itself
            if (cmd == CMD_HALT) begin
                halted <= 1'b1;
            end else begin
                pc <= pc + PC_STEP;
            end

            if (cmd == CMD_NOP) begin
                illegal <= 1'b1;  // sticky until reset
            end
        end
    end

endmodule

//--- core_host_port.sv
`include "core_params.svh"

module core_host_port import rv_isa_pkg::*, core_apb_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`CORE_APB_AW-1:0] paddr,
    input  logic [`CORE_XLEN-1:0]   pwdata,
    output logic [`CORE_XLEN-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,
    output inst_u                   inst,
    output logic                    exec_valid,
    output logic [`CORE_REG_AW-1:0] host_raddr,
    input  logic [`CORE_XLEN-1:0]   host_rdata,
    input  logic [`CORE_XLEN-1:0]   pc,
    input  logic                    halted,
    input  logic                    illegal
);

    logic                  access;
    logic                  is_reg;
    logic                  rd_mapped;
    logic                  wr_ok;
    logic                  inst_we;
    logic [`CORE_XLEN-1:0] status;

    assign access = psel && penable;

    // 0x80..0xFC, word aligned
    assign is_reg     = (paddr >= ADDR_REG_BASE) && (paddr[1:0] == 2'b00);
    assign host_raddr = paddr[`CORE_REG_AW+1:2];

    assign rd_mapped = (paddr == ADDR_INST) || (paddr == ADDR_PC) ||
                       (paddr == ADDR_STATUS) || is_reg;

    // Only the instruction register is writable, and not once halted
    assign wr_ok   = (paddr == ADDR_INST) && !halted;
    assign inst_we = access && pwrite && wr_ok;

    assign pready  = 1'b1;  // no wait states
    assign pslverr = access && (pwrite ? !wr_ok : !rd_mapped);

    always_comb begin
        status               = '0;
        status[STAT_HALTED]  = halted;
        status[STAT_ILLEGAL] = illegal;
    end

    always_comb begin
        prdata = '0;
        if (is_reg) begin
            prdata = host_rdata;
        end else begin
            case (paddr)
                ADDR_INST:   prdata = inst;
                ADDR_PC:     prdata = pc;
                ADDR_STATUS: prdata = status;
                default:     prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst       <= '0;  // decodes as a harmless nop
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= inst_we;  // one cycle, APB can't issue back to back
            if (inst_we) begin
                inst <= pwdata;
            end
        end
    end

endmodule

//--- core_top.sv
`include "core_params.svh"

module core_top import rv_isa_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`CORE_APB_AW-1:0] paddr,
    input  logic [`CORE_XLEN-1:0]   pwdata,
    output logic [`CORE_XLEN-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr
);

    inst_u                   inst;
    logic                    exec_valid;
    logic [`CORE_REG_AW-1:0] host_raddr;
    logic [`CORE_XLEN-1:0]   host_rdata;
    logic [`CORE_XLEN-1:0]   pc;
    logic                    halted;
    logic                    illegal;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   imm;
    logic                    use_pc;
    cmd_e                    cmd;
    logic                    wen;
    logic [`CORE_REG_AW-1:0] waddr;
    logic [`CORE_XLEN-1:0]   wdata;

    core_host_port u_host_port (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .inst       (inst),
        .exec_valid (exec_valid),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata),
        .pc         (pc),
        .halted     (halted),
        .illegal    (illegal)
    );

    // Decoder and register file see the same word in the exec cycle
    core_idu u_idu (
        .inst     (inst),
        .rs1_addr (rs1_addr),
        .rd       (rd),
        .imm      (imm),
        .use_pc   (use_pc),
        .cmd      (cmd)
    );

    core_regfile u_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs1_addr   (rs1_addr),
        .host_raddr (host_raddr),
        .wen        (wen),
        .waddr      (waddr),
        .wdata      (wdata),
        .rs1_data   (rs1_data),
        .host_rdata (host_rdata)
    );

    core_exu u_exu (
        .clk        (clk),
        .arst_n     (arst_n),
        .exec_valid (exec_valid),
        .rs1_data   (rs1_data),
        .rd         (rd),
        .imm        (imm),
        .use_pc     (use_pc),
        .cmd        (cmd),
        .wen        (wen),
        .waddr      (waddr),
        .wdata      (wdata),
        .pc         (pc),
        .halted     (halted),
        .illegal    (illegal)
    );

endmodule

//--- core_properties.sv
`include "core_params.svh"

module core_properties (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  penable,
    input logic                  pready,
    input logic                  exec_valid,
    input logic                  halted,
    input logic [`CORE_XLEN-1:0] pc
);

    // Single-cycle exec pulse
    a_exec_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        exec_valid |=> !exec_valid)
        else $error("exec_valid stayed high for more than one cycle");

    a_no_wait: assert property (@(posedge clk) disable iff (!arst_n) penable |-> pready)
        else $error("pready low during an access cycle");

    a_pc_frozen: assert property (@(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
        else $error("pc moved while the core was halted");

endmodule

bind core_top core_properties u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .penable    (penable),
    .pready     (pready),
    .exec_valid (exec_valid),
    .halted     (halted),
    .pc         (pc)
);

//--- core_tb.sv
`include "core_params.svh"

module core_tb;

    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = 10 * NUM_ROWS + 100;

    // RV32I base opcodes
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_SYS   = 7'b1110011;

    // Two read-only offsets written then an unmapped and a misaligned read
    localparam logic [31:0] BAD_ADDRS = {8'h82, 8'h0c, 8'h08, 8'h04};

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`CORE_APB_AW-1:0] paddr;
    logic [`CORE_XLEN-1:0]   pwdata;
    logic [`CORE_XLEN-1:0]   prdata;
    logic                    pready;
    logic                    pslverr;

    string       row_name [NUM_ROWS];
    logic [31:0] row_word [NUM_ROWS];
    int          row_reg  [NUM_ROWS];
    logic [31:0] row_exp  [NUM_ROWS][3];  // register, pc, status after the row
    int          n_rows = 0;

    // Architectural state of the model
    logic [31:0] model_regs [32];
    logic [31:0] model_pc   = `CORE_RESET_PC;
    logic        model_halt = 1'b0;
    logic        model_ill  = 1'b0;

    int cycles = 0;
    int errs   = 0;  // in the running test
    int n_ok   = 0;
    int n_bad  = 0;

    core_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the APB sequence never completed", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Runs one word on the model by the RV32I rules
    task automatic model_exec(input logic [31:0] w);
        logic [31:0] res;
        logic        wr;
        res = '0;
        wr  = 1'b0;
        case (w[6:0])
            OP_IMM: begin
                wr  = (w[14:12] == 3'b000);
                res = model_regs[w[19:15]] + {{20{w[31]}}, w[31:20]};
            end
            OP_LUI: begin
                wr  = 1'b1;
                res = {w[31:12], 12'h000};
            end
            OP_AUIPC: begin
                wr  = 1'b1;
                res = model_pc + {w[31:12], 12'h000};
            end
            default: ;
        endcase
        if (w[6:0] == OP_SYS && w[14:12] == 3'b000 && w[31:20] == 12'h001) begin
            model_halt = 1'b1;  // ebreak leaves the PC in place
        end else begin
            model_ill = model_ill || !wr;
            model_pc  = model_pc + 4;
            if (wr && w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = res;
            end
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] w, input int chk);
        model_exec(w);
        row_name[n_rows]   = name;
        row_word[n_rows]   = w;
        row_reg[n_rows]    = chk;
        row_exp[n_rows][0] = model_regs[chk];
        row_exp[n_rows][1] = model_pc;
        row_exp[n_rows][2] = {30'd0, model_ill, model_halt};
        n_rows++;
    endtask

    task automatic build_table();
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [31:0] r;
        add_row("addi_pos",    {12'd5,   5'd0, 3'b000, 5'd1, OP_IMM}, 1);
        add_row("addi_neg",    {12'hffd, 5'd1, 3'b000, 5'd2, OP_IMM}, 2);
        add_row("addi_chain",  {12'h7ff, 5'd2, 3'b000, 5'd3, OP_IMM}, 3);
        add_row("addi_x0",     {12'd7,   5'd1, 3'b000, 5'd0, OP_IMM}, 0);
        add_row("lui_fixed",   {20'h12345, 5'd4, OP_LUI}, 4);
        add_row("auipc_fixed", {20'h00001, 5'd5, OP_AUIPC}, 5);
        for (int k = 0; k < 8; k++) begin
            rd = 5'd1 + 5'($urandom % 31);
            rs = 5'($urandom % 32);
            r  = $urandom;
            case (k % 4)
                0, 1: add_row($sformatf("rnd_addi_%0d", k),
                              {r[11:0], rs, 3'b000, rd, OP_IMM}, rd);
                2: add_row($sformatf("rnd_lui_%0d", k), {r[19:0], rd, OP_LUI}, rd);
                default: add_row($sformatf("rnd_auipc_%0d", k), {r[19:0], rd, OP_AUIPC}, rd);
            endcase
        end
        add_row("illegal_op", 32'h0050_80ff, 1);  // addi x1,x1,5 with opcode 7f
        add_row("ebreak",     32'h0010_0073, 1);
    endtask

    function automatic logic [`CORE_APB_AW-1:0] reg_addr(input int n);
        return 8'h80 + 8'(4 * n);
    endfunction

    // Setup then access with data sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            $display("APB access to offset %h ended with pready low", addr);
            errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errs == 0) begin
            $display("%-14s ok", name);
            n_ok++;
        end else begin
            $display("%-14s %0d error(s)", name, errs);
            n_bad++;
        end
        errs = 0;
    endtask

    initial begin
        logic [31:0] got [3];
        logic [31:0] rdata;
        logic        err;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h8c7b));
        for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
        end
        build_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        apb_xfer(1'b0, 8'h04, '0, rdata, err);
        if (rdata !== `CORE_RESET_PC) begin
            $display("ERROR reset_state pc: expected %h, actual %h", `CORE_RESET_PC, rdata);
            errs++;
        end
        apb_xfer(1'b0, 8'h08, '0, rdata, err);
        if (rdata !== 32'h0) begin
            $display("ERROR reset_state status: expected %h, actual %h", 32'h0, rdata);
            errs++;
        end
        for (int n = 1; n < 32; n += 15) begin  // x1, x16, x31
            apb_xfer(1'b0, reg_addr(n), '0, rdata, err);
            if (rdata !== 32'h0) begin
                $display("ERROR reset_state x%0d: expected %h, actual %h", n, 32'h0, rdata);
                errs++;
            end
        end
        finish_test("reset_state");

        for (int t = 0; t < n_rows; t++) begin
            apb_xfer(1'b1, 8'h00, row_word[t], rdata, err);
            if (err !== 1'b0) begin
                $display("%s: instruction write was refused with pslverr", row_name[t]);
                errs++;
            end
            apb_xfer(1'b0, reg_addr(row_reg[t]), '0, got[0], err);
            apb_xfer(1'b0, 8'h04, '0, got[1], err);
            apb_xfer(1'b0, 8'h08, '0, got[2], err);
            for (int k = 0; k < 3; k++) begin
                if (got[k] !== row_exp[t][k]) begin
                    $display("ERROR %s %s: expected %h, actual %h", row_name[t],
                             k == 0 ? "register" : (k == 1 ? "pc" : "status"),
                             row_exp[t][k], got[k]);
                    errs++;
                end
            end
            finish_test(row_name[t]);
        end

        // Halted now
        apb_xfer(1'b1, 8'h00, {12'd99, 5'd0, 3'b000, 5'd1, OP_IMM}, rdata, err);
        if (err !== 1'b1) begin
            $display("after_halt: instruction write was accepted while halted");
            errs++;
        end
        apb_xfer(1'b0, 8'h04, '0, rdata, err);
        if (rdata !== model_pc) begin
            $display("ERROR after_halt pc: expected %h, actual %h", model_pc, rdata);
            errs++;
        end
        for (int n = 0; n < 32; n++) begin
            apb_xfer(1'b0, reg_addr(n), '0, rdata, err);
            if (rdata !== model_regs[n]) begin
                $display("ERROR after_halt x%0d: expected %h, actual %h", n, model_regs[n], rdata);
                errs++;
            end
        end
        finish_test("after_halt");

        for (int k = 0; k < 4; k++) begin
            apb_xfer(k < 2, BAD_ADDRS[8*k +: 8], 32'hffff_ffff, rdata, err);
            if (err !== 1'b1) begin
                $display("bad_access: no pslverr on access to offset %h", BAD_ADDRS[8*k +: 8]);
                errs++;
            end
        end
        apb_xfer(1'b0, 8'h04, '0, rdata, err);
        if (rdata !== model_pc) begin
            $display("ERROR bad_access pc: expected %h, actual %h", model_pc, rdata);
            errs++;
        end
        finish_test("bad_access");

        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        @(posedge clk);
        $display("summary: %0d tests, %0d ok, %0d with errors", n_ok + n_bad, n_ok, n_bad);
        if (n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
rv_isa_pkg.sv
core_apb_pkg.sv
core_idu.sv
core_regfile.sv
core_exu.sv
core_host_port.sv
core_top.sv
core_properties.sv
core_tb.sv
